//--- hdl/mem_cfg_pkg.sv
`default_nettype none

package mem_cfg_pkg;

   // word size of every bank and of the top-level data ports
   parameter int DATA_W = 32;

   // global word address, interleaved across the banks by its low bits
   parameter int ADDR_W = 8;

   // total number of words over all banks
   parameter int WORDS = 1 << ADDR_W;

   // result of a read and a write to one address in the same cycle
   typedef enum logic
   {
      RW_OLD_DATA = 1'b0,
      // read sees the word being written
      RW_NEW_DATA = 1'b1
   } rw_policy_e;

endpackage : mem_cfg_pkg

`default_nettype wire

//--- hdl/mem_port_pkg.sv
`default_nettype none

package mem_port_pkg;

   import mem_cfg_pkg::*;

   // top-level write port, one strobe per request
   typedef struct packed
   {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } wr_req_t;

   // top-level read port, data returns one cycle later
   typedef struct packed
   {
      logic              valid;
      logic [ADDR_W-1:0] addr;
   } rd_req_t;

   // held read word of one bank
   typedef struct packed
   {
      logic [DATA_W-1:0] data;
   } bank_rd_t;

endpackage : mem_port_pkg

`default_nettype wire

//--- hdl/mem_1r1w_sync_synth.sv
`default_nettype none

module mem_1r1w_sync_synth #(
   parameter int                      els_p         = 64,
   parameter mem_cfg_pkg::rw_policy_e rw_policy_p   = mem_cfg_pkg::RW_OLD_DATA,
   localparam int                     addr_width_lp = $clog2(els_p)
) (
   input  logic                            clk_i,
   input  logic                            rst_n_i,

   input  logic                            w_v_i,
   input  logic [addr_width_lp-1:0]        w_addr_i,
   input  logic [mem_cfg_pkg::DATA_W-1:0]  w_data_i,

   input  logic                            r_v_i,
   input  logic [addr_width_lp-1:0]        r_addr_i,

   output logic [mem_cfg_pkg::DATA_W-1:0]  r_data_o
);

   import mem_cfg_pkg::*;

   // storage words, contents are undefined until written
   logic [DATA_W-1:0] mem_r [els_p];

   logic same_addr_w;
   logic fwd_new_w;

   // write and read hit the same word in this cycle
   assign same_addr_w = w_v_i & r_v_i & (w_addr_i == r_addr_i);

   // new data wins only under the forwarding policy
   assign fwd_new_w = (rw_policy_p == RW_NEW_DATA) & same_addr_w;

   always_ff @(posedge clk_i)
   begin
      if (w_v_i)
      begin
         mem_r[w_addr_i] <= w_data_i;
      end
   end

   // registered read, the word is kept until the next read strobe
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         r_data_o <= '0;
      end
      else if (r_v_i)
      begin
         if (fwd_new_w)
         begin
            r_data_o <= w_data_i;
         end
         else
         begin
            // array still holds the old word at this edge
            r_data_o <= mem_r[r_addr_i];
         end
      end
   end

endmodule : mem_1r1w_sync_synth

`default_nettype wire

//--- hdl/mem_1r1w_sync.sv
`default_nettype none

module mem_1r1w_sync #(
   parameter int                      els_p                 = 64,
   parameter mem_cfg_pkg::rw_policy_e rw_policy_p           = mem_cfg_pkg::RW_OLD_DATA,
   parameter bit                      enable_clock_gating_p = 1'b1,
   localparam int                     addr_width_lp         = $clog2(els_p)
) (
   input  logic                            clk_i,
   input  logic                            rst_n_i,

   input  logic                            w_v_i,
   input  logic [addr_width_lp-1:0]        w_addr_i,
   input  logic [mem_cfg_pkg::DATA_W-1:0]  w_data_i,

   input  logic                            r_v_i,
   input  logic [addr_width_lp-1:0]        r_addr_i,

   output logic [mem_cfg_pkg::DATA_W-1:0]  r_data_o
);

   logic clk_bank_w;

   if (enable_clock_gating_p)
   begin : g_clk_gate
      logic clk_en_w;
      logic clk_en_latch_r;

      // bank is only clocked in cycles that carry a strobe
      assign clk_en_w = w_v_i | r_v_i;

      // enable settles while the clock is low, no glitch on the high phase
      always_latch
      begin
         if (!clk_i)
         begin
            clk_en_latch_r <= clk_en_w;
         end
      end

      assign clk_bank_w = clk_i & clk_en_latch_r;
   end
   else
   begin : g_no_clk_gate
      assign clk_bank_w = clk_i;
   end

   mem_1r1w_sync_synth #(
      .els_p       (els_p),
      .rw_policy_p (rw_policy_p)
   ) u_synth (
      .clk_i    (clk_bank_w),
      .rst_n_i  (rst_n_i),
      .w_v_i    (w_v_i),
      .w_addr_i (w_addr_i),
      .w_data_i (w_data_i),
      .r_v_i    (r_v_i),
      .r_addr_i (r_addr_i),
      .r_data_o (r_data_o)
   );

endmodule : mem_1r1w_sync

`default_nettype wire

//--- hdl/bank_dispatch.sv
`default_nettype none

module bank_dispatch #(
   parameter int  banks_p             = 4,
   localparam int sel_width_lp        = $clog2(banks_p),
   localparam int local_addr_width_lp = mem_cfg_pkg::ADDR_W - sel_width_lp
) (
   input  mem_port_pkg::wr_req_t              wr_i,
   input  mem_port_pkg::rd_req_t              rd_i,

   output logic [banks_p-1:0]                 bank_w_v_o,
   output logic [banks_p-1:0]                 bank_r_v_o,

   output logic [local_addr_width_lp-1:0]     bank_w_addr_o,
   output logic [local_addr_width_lp-1:0]     bank_r_addr_o,
   output logic [mem_cfg_pkg::DATA_W-1:0]     bank_w_data_o,

   output logic [sel_width_lp-1:0]            rd_bank_o
);

   import mem_cfg_pkg::*;

   logic [sel_width_lp-1:0] wr_bank_w;
   logic [sel_width_lp-1:0] rd_bank_w;

   // low address bits pick the bank
   assign wr_bank_w = wr_i.addr[sel_width_lp-1:0];
   assign rd_bank_w = rd_i.addr[sel_width_lp-1:0];

   // remaining high bits address the word inside the bank
   assign bank_w_addr_o = wr_i.addr[ADDR_W-1:sel_width_lp];
   assign bank_r_addr_o = rd_i.addr[ADDR_W-1:sel_width_lp];

   // one write bus shared by every bank, the strobe selects the target
   assign bank_w_data_o = wr_i.data;

   // merge stage needs the bank of the current read
   assign rd_bank_o = rd_bank_w;

   // one-hot strobes, qualified by the request valid bits
   always_comb
   begin
      for (int b = 0; b < banks_p; b++)
      begin
         bank_w_v_o[b] = wr_i.valid & (wr_bank_w == sel_width_lp'(b));
         bank_r_v_o[b] = rd_i.valid & (rd_bank_w == sel_width_lp'(b));
      end
   end

endmodule : bank_dispatch

`default_nettype wire

//--- hdl/bank_read_merge.sv
`default_nettype none

module bank_read_merge #(
   parameter int  banks_p      = 4,
   localparam int sel_width_lp = $clog2(banks_p)
) (
   input  logic                            clk_i,
   input  logic                            rst_n_i,

   input  logic                            rd_v_i,
   input  logic [sel_width_lp-1:0]         rd_bank_i,

   input  mem_port_pkg::bank_rd_t          bank_rd_i [banks_p],

   output logic [mem_cfg_pkg::DATA_W-1:0]  rd_data_o
);

   // bank whose read register carries the latest read
   logic [sel_width_lp-1:0] rd_bank_r;

   // captured on the same edge as the bank's own read register
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rd_bank_r <= '0;
      end
      else if (rd_v_i)
      begin
         rd_bank_r <= rd_bank_i;
      end
   end

   // banks hold their last read, so the mux output holds too
   assign rd_data_o = bank_rd_i[rd_bank_r].data;

endmodule : bank_read_merge

`default_nettype wire

//--- hdl/banked_mem_top.sv
`default_nettype none

module banked_mem_top #(
   parameter int                      banks_p               = 4,
   parameter mem_cfg_pkg::rw_policy_e rw_policy_p           = mem_cfg_pkg::RW_OLD_DATA,
   parameter bit                      enable_clock_gating_p = 1'b1
) (
   input  logic                            clk_i,
   input  logic                            rst_n_i,

   input  mem_port_pkg::wr_req_t           wr_i,
   input  mem_port_pkg::rd_req_t           rd_i,

   output logic [mem_cfg_pkg::DATA_W-1:0]  rd_data_o
);

   import mem_cfg_pkg::*;
   import mem_port_pkg::*;

   localparam int sel_width_lp        = $clog2(banks_p);
   localparam int local_addr_width_lp = ADDR_W - sel_width_lp;
   // words per bank
   localparam int bank_els_lp         = WORDS / banks_p;

   logic [banks_p-1:0]             bank_w_v_w;
   logic [banks_p-1:0]             bank_r_v_w;
   logic [local_addr_width_lp-1:0] bank_w_addr_w;
   logic [local_addr_width_lp-1:0] bank_r_addr_w;
   logic [DATA_W-1:0]              bank_w_data_w;
   logic [sel_width_lp-1:0]        rd_bank_w;
   bank_rd_t                       bank_rd_w [banks_p];

   bank_dispatch #(
      .banks_p (banks_p)
   ) u_dispatch (
      .wr_i          (wr_i),
      .rd_i          (rd_i),
      .bank_w_v_o    (bank_w_v_w),
      .bank_r_v_o    (bank_r_v_w),
      .bank_w_addr_o (bank_w_addr_w),
      .bank_r_addr_o (bank_r_addr_w),
      .bank_w_data_o (bank_w_data_w),
      .rd_bank_o     (rd_bank_w)
   );

   for (genvar b = 0; b < banks_p; b++)
   begin : g_bank
      mem_1r1w_sync #(
         .els_p                 (bank_els_lp),
         .rw_policy_p           (rw_policy_p),
         .enable_clock_gating_p (enable_clock_gating_p)
      ) u_bank (
         .clk_i    (clk_i),
         .rst_n_i  (rst_n_i),
         .w_v_i    (bank_w_v_w[b]),
         .w_addr_i (bank_w_addr_w),
         .w_data_i (bank_w_data_w),
         .r_v_i    (bank_r_v_w[b]),
         .r_addr_i (bank_r_addr_w),
         .r_data_o (bank_rd_w[b].data)
      );
   end

   bank_read_merge #(
      .banks_p (banks_p)
   ) u_merge (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .rd_v_i    (rd_i.valid),
      .rd_bank_i (rd_bank_w),
      .bank_rd_i (bank_rd_w),
      .rd_data_o (rd_data_o)
   );

endmodule : banked_mem_top

`default_nettype wire

//--- verif/clk_gen.sv
`default_nettype none

module clk_gen #(
   parameter int period_p = 40
) (
   output logic clk_o
);

   // starts low, first rising edge after half a period
   initial
   begin
      clk_o = 1'b0;
      forever
      begin
         #(period_p / 2);
         clk_o = ~clk_o;
      end
   end

endmodule : clk_gen

`default_nettype wire

//--- verif/banked_mem_tb.sv
`default_nettype none

module banked_mem_tb #(
   parameter int                      banks_p     = 4,
   parameter mem_cfg_pkg::rw_policy_e rw_policy_p = mem_cfg_pkg::RW_OLD_DATA
);

   import mem_cfg_pkg::*;
   import mem_port_pkg::*;

   localparam int timeout_lp    = 100000;
   localparam int reset_wait_lp = 10;

   // one table row, the stimulus of one cycle and whether its result is checked
   typedef struct packed
   {
      logic [2:0]        test;
      logic              wr_v;
      logic [ADDR_W-1:0] wr_addr;
      logic [DATA_W-1:0] wr_data;
      logic              rd_v;
      logic [ADDR_W-1:0] rd_addr;
      logic              chk;
   } entry_t;

   logic              clk;
   logic              rst_n;
   wr_req_t           wr_req;
   rd_req_t           rd_req;
   logic [DATA_W-1:0] rd_data;

   entry_t            table_q [$];
   string             test_names [6];
   logic [DATA_W-1:0] ref_mem [WORDS];
   logic [DATA_W-1:0] exp_data;
   int                seed;
   int                checks;
   int                errors;
   int                test_checks;
   int                test_errors;
   bit                reset_seen;

   clk_gen #(
      .period_p (40)
   ) u_clk_gen (
      .clk_o (clk)
   );

   banked_mem_top #(
      .banks_p               (banks_p),
      .rw_policy_p           (rw_policy_p),
      .enable_clock_gating_p (1'b1)
   ) dut (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .wr_i      (wr_req),
      .rd_i      (rd_req),
      .rd_data_o (rd_data)
   );

   task automatic add_entry(input int test, input int wr_v, input int wr_addr,
                            input logic [DATA_W-1:0] wr_data, input int rd_v,
                            input int rd_addr, input int chk);
      entry_t e;
      e.test    = 3'(test);
      e.wr_v    = (wr_v != 0);
      e.wr_addr = ADDR_W'(wr_addr);
      e.wr_data = wr_data;
      e.rd_v    = (rd_v != 0);
      e.rd_addr = ADDR_W'(rd_addr);
      e.chk     = (chk != 0);
      table_q.push_back(e);
   endtask

   task automatic build_table();
      int a;
      add_entry(1, 0, 0, '0, 0, 0, 1);
      // fill every word, then read it all back across the interleaved banks
      for (a = 0; a < WORDS; a++)
      begin
         add_entry(2, 1, a, $random(seed), 0, 0, 0);
      end
      for (a = 0; a < WORDS; a++)
      begin
         add_entry(2, 0, 0, '0, 1, a, 1);
      end
      // other bank, then same bank at another word
      add_entry(3, 1, 5, $random(seed), 1, 6, 1);
      add_entry(3, 1, 8, $random(seed), 1, 12, 1);
      add_entry(3, 1, 13, $random(seed), 1, 9, 1);
      add_entry(3, 0, 0, '0, 1, 5, 1);
      add_entry(3, 0, 0, '0, 1, 8, 1);
      add_entry(3, 0, 0, '0, 1, 13, 1);
      // same word written and read in one cycle
      add_entry(4, 1, 20, $random(seed), 1, 20, 1);
      add_entry(4, 1, 33, $random(seed), 1, 33, 1);
      add_entry(4, 1, 40, $random(seed), 1, 40, 1);
      add_entry(4, 1, 40, $random(seed), 1, 40, 1);
      add_entry(4, 0, 0, '0, 1, 20, 1);
      add_entry(4, 0, 0, '0, 1, 33, 1);
      add_entry(4, 0, 0, '0, 1, 40, 1);
      // hold of the last read, also across a write to the word just read
      add_entry(5, 0, 0, '0, 1, 30, 1);
      add_entry(5, 0, 0, '0, 0, 0, 1);
      add_entry(5, 0, 0, '0, 0, 0, 1);
      add_entry(5, 1, 30, $random(seed), 0, 0, 1);
      add_entry(5, 0, 0, '0, 0, 0, 1);
      add_entry(5, 1, 31, $random(seed), 0, 0, 1);
      add_entry(5, 1, 34, $random(seed), 0, 0, 1);
      add_entry(5, 0, 0, '0, 0, 0, 1);
      add_entry(5, 0, 0, '0, 1, 30, 1);
      add_entry(5, 0, 0, '0, 0, 0, 1);
   endtask

   task automatic drive_entry(input entry_t e);
      wr_req_t w;
      rd_req_t r;
      w.valid = e.wr_v;
      w.addr  = e.wr_addr;
      w.data  = e.wr_data;
      r.valid = e.rd_v;
      r.addr  = e.rd_addr;
      wr_req <= w;
      rd_req <= r;
   endtask

   task automatic model_and_check(input entry_t e);
      if (e.rd_v)
      begin
         if (e.wr_v && (e.wr_addr == e.rd_addr) && (rw_policy_p == RW_NEW_DATA))
         begin
            exp_data = e.wr_data;
         end
         else
         begin
            exp_data = ref_mem[e.rd_addr];
         end
      end
      // array update comes after the read, a collision sees the old word
      if (e.wr_v)
      begin
         ref_mem[e.wr_addr] = e.wr_data;
      end
      if (e.chk)
      begin
         checks++;
         test_checks++;
         if (rd_data !== exp_data)
         begin
            errors++;
            test_errors++;
            $display("MISMATCH rd_data_o expected 0x%08h actual 0x%08h", exp_data, rd_data);
         end
      end
   endtask

   task automatic report_test(input int t);
      $display("test %0d %s: %0d checks, %0d errors", t, test_names[t], test_checks,
               test_errors);
      test_checks = 0;
      test_errors = 0;
   endtask

   initial
   begin : reset_seq
      rst_n = 1'b1;
      #1;
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
   end

   initial
   begin : watchdog
      #(timeout_lp);
      $display("timeout: the run did not finish within %0d time units", timeout_lp);
      $display("ERRORS FOUND");
      $finish;
   end

   initial
   begin : main
      int i;
      int wait_cnt;
      wr_req        = '0;
      rd_req        = '0;
      seed          = 9;
      checks        = 0;
      errors        = 0;
      test_checks   = 0;
      test_errors   = 0;
      exp_data      = '0;
      test_names[1] = "reset value";
      test_names[2] = "fill and read back";
      test_names[3] = "read and write to different words";
      test_names[4] = "same address collision";
      test_names[5] = "hold between reads";
      build_table();
      wait_cnt   = 0;
      reset_seen = 1'b0;
      while (!reset_seen && (wait_cnt < reset_wait_lp))
      begin
         @(negedge clk);
         wait_cnt++;
         reset_seen = (rst_n === 1'b1);
      end
      if (!reset_seen)
      begin
         $display("reset was not released within %0d cycles", reset_wait_lp);
         errors++;
      end
      else
      begin
         // row i is driven while the result of row i-1 is checked
         for (i = 0; i <= table_q.size(); i++)
         begin
            @(posedge clk);
            if (i < table_q.size())
            begin
               drive_entry(table_q[i]);
            end
            else
            begin
               wr_req <= '0;
               rd_req <= '0;
            end
            @(negedge clk);
            if (i > 0)
            begin
               model_and_check(table_q[i-1]);
               if ((i == table_q.size()) || (table_q[i].test != table_q[i-1].test))
               begin
                  report_test(int'(table_q[i-1].test));
               end
            end
         end
      end
      $display("total: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
      begin
         $display("NO ERRORS");
      end
      else
      begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule : banked_mem_tb

`default_nettype wire

//--- filelist.f
hdl/mem_cfg_pkg.sv
hdl/mem_port_pkg.sv
hdl/mem_1r1w_sync_synth.sv
hdl/mem_1r1w_sync.sv
hdl/bank_dispatch.sv
hdl/bank_read_merge.sv
hdl/banked_mem_top.sv
verif/clk_gen.sv
verif/banked_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the banked memory testbench, the verdict comes from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module banked_mem_tb \
   -f filelist.f -o banked_mem_sim || { echo "build failed"; exit 1; }
./obj_dir/banked_mem_sim > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
